//--- design/banked_ram.sv
module banked_ram #(
  parameter int NUM_BANKS = 4
) (
  input logic        clk,
  input logic        resetn,
  mem_bus_if.target  bus
);
  import soc_mem_pkg::*;

  localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [BANK_AW-1:0] word_idx;
  logic [SEL_W-1:0]   bank_sel;
  logic [SEL_W-1:0]   sel_q0;
  logic [SEL_W-1:0]   sel_q1;

  logic valid_q;
  logic write_q;
  logic ready1;
  logic ready2;
  logic resp_ready;

  strb_t bank_we      [NUM_BANKS];
  data_t bank_rdata   [NUM_BANKS];
  data_t bank_rdata_q [NUM_BANKS];

  assign word_idx = bus.addr[WORD_LSB +: BANK_AW];
  assign bank_sel = bus.addr[WORD_LSB + BANK_AW +: SEL_W];

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    // Strobes reach the selected bank only, and only before ready
    assign bank_we[i] = (bus.valid && !resp_ready && (bank_sel == SEL_W'(i))) ?
                        bus.wstrb : '0;

    ram_bank bank_i (
      .clk       (clk),
      .en        (bus.valid),
      .word_addr (word_idx),
      .wdata     (bus.wdata),
      .we        (bank_we[i]),
      .rdata     (bank_rdata[i])
    );

    // Second read stage
    always_ff @(posedge clk) begin
      bank_rdata_q[i] <= bank_rdata[i];
    end
  end

  // Rising valid starts a request and fixes its direction
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= 1'b0;
      write_q <= 1'b0;
      ready1  <= 1'b0;
      ready2  <= 1'b0;
    end else begin
      valid_q <= bus.valid;
      ready1  <= bus.valid && !valid_q;
      ready2  <= ready1;
      if (bus.valid && !valid_q) begin
        write_q <= |bus.wstrb;
      end
    end
  end

  // Bank select follows the read data through both stages
  always_ff @(posedge clk) begin
    sel_q0 <= bank_sel;
    sel_q1 <= sel_q0;
  end

  // Writes answer after one cycle, reads after two
  assign resp_ready = write_q ? ready1 : ready2;

  assign bus.ready = resp_ready;
  assign bus.rdata = bank_rdata_q[sel_q1];

endmodule

//--- design/bus_decoder.sv
module bus_decoder #(
  parameter int NUM_BANKS = 4
) (
  input  logic                valid,
  input  soc_mem_pkg::addr_t  addr,
  input  soc_mem_pkg::data_t  wdata,
  input  soc_mem_pkg::strb_t  wstrb,
  output logic                ready,
  output soc_mem_pkg::data_t  rdata,
  mem_bus_if.requester        text_bus,
  mem_bus_if.requester        heap_bus,
  mem_bus_if.requester        io_bus
);
  import soc_mem_pkg::*;

  // Region size in bytes
  localparam addr_t REGION_BYTES = addr_t'(NUM_BANKS * BANK_WORDS * STRB_W);
  localparam addr_t HEAP_BASE    = TEXT_BASE + REGION_BYTES;

  region_e region;
  addr_t   text_off;
  addr_t   heap_off;
  addr_t   io_off;

  // Below its base an offset wraps to a large value, so one compare per region
  assign text_off = addr - TEXT_BASE;
  assign heap_off = addr - HEAP_BASE;
  assign io_off   = addr - IO_ADDR;

  always_comb begin
    if (text_off < REGION_BYTES) begin
      region = REGION_TEXT;
    end else if (heap_off < REGION_BYTES) begin
      region = REGION_HEAP;
    end else if (addr == IO_ADDR) begin
      region = REGION_IO;
    end else begin
      region = REGION_NONE;
    end
  end

  // Only the selected target sees valid
  assign text_bus.valid = valid && (region == REGION_TEXT);
  assign heap_bus.valid = valid && (region == REGION_HEAP);
  assign io_bus.valid   = valid && (region == REGION_IO);

  assign text_bus.addr = text_off;
  assign heap_bus.addr = heap_off;
  assign io_bus.addr   = io_off;

  assign text_bus.wdata = wdata;
  assign heap_bus.wdata = wdata;
  assign io_bus.wdata   = wdata;

  assign text_bus.wstrb = wstrb;
  assign heap_bus.wstrb = wstrb;
  assign io_bus.wstrb   = wstrb;

  // Response mux with no ready for unmapped addresses
  always_comb begin
    case (region)
      REGION_TEXT: begin
        ready = text_bus.ready;
        rdata = text_bus.rdata;
      end
      REGION_HEAP: begin
        ready = heap_bus.ready;
        rdata = heap_bus.rdata;
      end
      REGION_IO: begin
        ready = io_bus.ready;
        rdata = io_bus.rdata;
      end
      default: begin
        ready = 1'b0;
        rdata = '0;
      end
    endcase
  end

endmodule

//--- design/led_port.sv
module led_port (
  input  logic                          clk,
  input  logic                          resetn,
  mem_bus_if.target                     bus,
  output logic [soc_mem_pkg::LED_W-1:0] led
);
  import soc_mem_pkg::*;

  logic [LED_W-1:0] led_q;
  logic             ready_q;
  data_t            rdata_q;
  logic             access;

  // First cycle of a request
  assign access = bus.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      led_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
      if (access && (|bus.wstrb)) begin
        led_q <= bus.wdata[LED_W-1:0];
      end
    end
  end

  // Zero-extended read-back
  always_ff @(posedge clk) begin
    if (access && !(|bus.wstrb)) begin
      rdata_q <= {{(DATA_W - LED_W){1'b0}}, led_q};
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign led       = led_q;

endmodule

//--- design/mem_bus_if.sv
interface mem_bus_if;
  import soc_mem_pkg::*;

  // Request side
  logic  valid;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;

  // Response side
  logic  ready;
  data_t rdata;

  modport requester (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  modport target (
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

//--- design/ram_bank.sv
module ram_bank (
  input  logic                            clk,
  input  logic                            en,
  input  logic [soc_mem_pkg::BANK_AW-1:0] word_addr,
  input  soc_mem_pkg::data_t              wdata,
  input  soc_mem_pkg::strb_t              we,
  output soc_mem_pkg::data_t              rdata
);
  import soc_mem_pkg::*;

  localparam int LANE_W = DATA_W / STRB_W;

  data_t              mem [BANK_WORDS];
  logic [BANK_AW-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (en) begin
      addr_q <= word_addr;
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (we[lane]) begin
          mem[word_addr][lane*LANE_W +: LANE_W] <= wdata[lane*LANE_W +: LANE_W];
        end
      end
    end
  end

  // Registered address gives one cycle of read latency
  assign rdata = mem[addr_q];

endmodule

//--- design/soc_mem_pkg.sv
package soc_mem_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LED_W  = 4;

  // Block RAM geometry with 16 KB banks
  localparam int BANK_WORDS = 4096;
  localparam int BANK_AW    = $clog2(BANK_WORDS);

  // Byte offset bits below the word index
  localparam int WORD_LSB = $clog2(STRB_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Address map without the heap, whose base follows from the region size
  localparam addr_t TEXT_BASE = '0;
  localparam addr_t IO_ADDR   = 32'h8000_0000;

  typedef enum logic [1:0] {
    REGION_TEXT,
    REGION_HEAP,
    REGION_IO,
    REGION_NONE
  } region_e;

endpackage

//--- design/soc_mem_top.sv
module soc_mem_top #(
  parameter int NUM_BANKS = 4
) (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          valid,
  input  soc_mem_pkg::addr_t            addr,
  input  soc_mem_pkg::data_t            wdata,
  input  soc_mem_pkg::strb_t            wstrb,
  output logic                          ready,
  output soc_mem_pkg::data_t            rdata,
  output logic [soc_mem_pkg::LED_W-1:0] led
);

  // One link per target
  mem_bus_if text_bus ();
  mem_bus_if heap_bus ();
  mem_bus_if io_bus ();

  bus_decoder #(
    .NUM_BANKS (NUM_BANKS)
  ) decoder_i (
    .valid    (valid),
    .addr     (addr),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .ready    (ready),
    .rdata    (rdata),
    .text_bus (text_bus.requester),
    .heap_bus (heap_bus.requester),
    .io_bus   (io_bus.requester)
  );

  // Program text
  banked_ram #(
    .NUM_BANKS (NUM_BANKS)
  ) text_ram_i (
    .clk    (clk),
    .resetn (resetn),
    .bus    (text_bus.target)
  );

  // Heap directly above text
  banked_ram #(
    .NUM_BANKS (NUM_BANKS)
  ) heap_ram_i (
    .clk    (clk),
    .resetn (resetn),
    .bus    (heap_bus.target)
  );

  led_port led_port_i (
    .clk    (clk),
    .resetn (resetn),
    .bus    (io_bus.target),
    .led    (led)
  );

endmodule

//--- verification/mem_model.svh
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// Region geometry as seen from the bus
localparam int    REGION_WORDS = NUM_BANKS * BANK_WORDS;
localparam addr_t REGION_BYTES = addr_t'(REGION_WORDS * STRB_W);
localparam addr_t HEAP_START   = TEXT_BASE + REGION_BYTES;

// Words keyed by word index inside each region
data_t            text_words [int unsigned];
data_t            heap_words [int unsigned];
logic [LED_W-1:0] led_value = '0;

function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
  data_t result;
  result = old_word;
  for (int b = 0; b < STRB_W; b++) begin
    if (strb[b]) begin
      result[8*b +: 8] = new_word[8*b +: 8];
    end
  end
  return result;
endfunction

function automatic void apply_write(addr_t a, data_t wd, strb_t ws);
  int unsigned idx;
  data_t       old_word;
  old_word = '0;
  if (a == IO_ADDR) begin
    led_value = wd[LED_W-1:0];
  end else if (a - TEXT_BASE < REGION_BYTES) begin
    idx = (a - TEXT_BASE) >> 2;
    if (text_words.exists(idx)) begin
      old_word = text_words[idx];
    end
    text_words[idx] = merge_bytes(old_word, wd, ws);
  end else begin
    idx = (a - HEAP_START) >> 2;
    if (heap_words.exists(idx)) begin
      old_word = heap_words[idx];
    end
    heap_words[idx] = merge_bytes(old_word, wd, ws);
  end
endfunction

function automatic data_t predict_read(addr_t a);
  int unsigned idx;
  data_t       word;
  word = '0;
  if (a == IO_ADDR) begin
    word = data_t'(led_value);
  end else if (a - TEXT_BASE < REGION_BYTES) begin
    idx = (a - TEXT_BASE) >> 2;
    if (text_words.exists(idx)) begin
      word = text_words[idx];
    end
  end else begin
    idx = (a - HEAP_START) >> 2;
    if (heap_words.exists(idx)) begin
      word = heap_words[idx];
    end
  end
  return word;
endfunction

`endif

//--- verification/soc_mem_tb.sv
module soc_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_mem_pkg::*;

  localparam int NUM_BANKS      = 4;
  localparam int TIMEOUT_CYCLES = 20;

  logic             clk = 1'b0;
  logic             resetn;
  logic             valid;
  addr_t            addr;
  data_t            wdata;
  strb_t            wstrb;
  logic             ready;
  data_t            rdata;
  logic [LED_W-1:0] led;

  integer      seed;
  int unsigned text_offs [$];
  int unsigned heap_offs [$];

  `include "mem_model.svh"

  soc_mem_top #(
    .NUM_BANKS (NUM_BANKS)
  ) dut_i (
    .clk    (clk),
    .resetn (resetn),
    .valid  (valid),
    .addr   (addr),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .ready  (ready),
    .rdata  (rdata),
    .led    (led)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic int unsigned bounded_random(int unsigned limit);
    return {$random(seed)} % limit;
  endfunction

  function automatic data_t random_word();
    return data_t'($random(seed));
  endfunction

  // A zero strobe would turn the write into a read
  function automatic strb_t nonzero_strobe();
    return strb_t'(bounded_random(15) + 1);
  endfunction

  function automatic addr_t text_location(int unsigned off);
    return TEXT_BASE + addr_t'(off) * STRB_W;
  endfunction

  function automatic addr_t heap_location(int unsigned off);
    return HEAP_START + addr_t'(off) * STRB_W;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s expected=0x%08h actual=0x%08h",
               $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(addr_t a);
    $display("ERROR at %0t: no ready from the design for address 0x%08h", $time, a);
    $display("CHECKS FAILED");
    $fatal(1, "bus timeout");
  endtask

  // Starts at a falling edge, so the next rising edge is the first with valid high
  task automatic bus_access(input addr_t a, input data_t wd, input strb_t ws,
                            input int exp_latency, output data_t rd);
    int cycles;
    valid  = 1'b1;
    addr   = a;
    wdata  = wd;
    wstrb  = ws;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (ready !== 1'b1 && cycles >= TIMEOUT_CYCLES) begin
        report_timeout(a);
      end
    end while (ready !== 1'b1);
    rd = rdata;
    check_value("ready latency", exp_latency, cycles);
    // Address is held so the idle check watches the same target
    valid = 1'b0;
    wdata = '0;
    wstrb = '0;
    @(negedge clk);
    // ready is a single-cycle pulse
    check_value("ready", 0, ready);
  endtask

  task automatic write_word(addr_t a, data_t wd, strb_t ws);
    data_t unused;
    bus_access(a, wd, ws, 1, unused);
    apply_write(a, wd, ws);
  endtask

  task automatic read_and_compare(addr_t a);
    data_t got;
    int    latency;
    latency = (a == IO_ADDR) ? 1 : 2;
    bus_access(a, '0, '0, latency, got);
    check_value("rdata", predict_read(a), got);
  endtask

  initial begin
    int          i;
    int unsigned off;
    data_t       d;
    seed   = 30360;
    resetn = 1'b0;
    valid  = 1'b0;
    addr   = '0;
    wdata  = '0;
    wstrb  = '0;
    repeat (16) @(negedge clk);
    resetn = 1'b1;

    // Quiet bus after reset
    repeat (6) begin
      @(negedge clk);
      check_value("ready", 0, ready);
      check_value("led", 0, led);
    end

    // Full-word text writes first so no byte stays undefined
    for (i = 0; i < 40; i++) begin
      off = bounded_random(REGION_WORDS);
      write_word(text_location(off), random_word(), '1);
      text_offs.push_back(off);
    end
    for (i = 0; i < 40; i++) begin
      off = text_offs[bounded_random(text_offs.size())];
      write_word(text_location(off), random_word(), nonzero_strobe());
      off = text_offs[bounded_random(text_offs.size())];
      read_and_compare(text_location(off));
    end

    // Heap and text at equal offsets must stay apart
    for (i = 0; i < 32; i++) begin
      off = bounded_random(REGION_WORDS);
      write_word(heap_location(off), random_word(), '1);
      write_word(text_location(off), random_word(), '1);
      heap_offs.push_back(off);
    end
    for (i = 0; i < 32; i++) begin
      off = heap_offs[bounded_random(heap_offs.size())];
      write_word(heap_location(off), random_word(), nonzero_strobe());
      read_and_compare(heap_location(off));
      read_and_compare(text_location(off));
    end

    // LED register
    for (i = 0; i < 8; i++) begin
      d = random_word();
      write_word(IO_ADDR, d, nonzero_strobe());
      check_value("led", d[LED_W-1:0], led);
      read_and_compare(IO_ADDR);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verification
design/soc_mem_pkg.sv
design/mem_bus_if.sv
design/ram_bank.sv
design/banked_ram.sv
design/led_port.sv
design/bus_decoder.sv
design/soc_mem_top.sv
verification/soc_mem_tb.sv
